/* design/uart_cmd_pkg.sv */
package uart_cmd_pkg;

	// Serial timing
	localparam int BAUD_DIV   = 8;	// clk cycles per b_tick
	localparam int OVERSAMPLE = 4;	// b_ticks per serial bit
	localparam int DIV_W      = $clog2(BAUD_DIV);
	localparam int TICK_W     = $clog2(OVERSAMPLE);

	// Register bank
	localparam int REG_COUNT = 8;
	localparam int ADDR_W    = $clog2(REG_COUNT);

	// Host opcodes, first byte of a command frame
	typedef enum logic [7:0] {
		OP_WRITE = 8'h01,
		OP_READ  = 8'h02,
		OP_ADD   = 8'h03,
		OP_XOR   = 8'h04,
		OP_BAD   = 8'hff	// Any undefined code
	} cmd_op_e;

	// First byte of a response frame
	typedef enum logic [7:0] {
		STAT_OK       = 8'h00,
		STAT_BAD_OP   = 8'he1,
		STAT_BAD_ADDR = 8'he2
	} status_e;

	// Five serial states need three bits
	typedef enum logic [2:0] {
		ST_IDLE   = 3'd0,
		ST_START  = 3'd1,
		ST_DATA   = 3'd2,
		ST_PARITY = 3'd3,
		ST_STOP   = 3'd4
	} ser_state_e;

endpackage

/* design/cmd_if.sv */
`timescale 1ns/1ps

// Decoded command, decode to execute
interface cmd_if;
	import uart_cmd_pkg::*;

	logic        valid;	// One-cycle pulse
	cmd_op_e     op;
	logic [7:0]  addr;
	logic [7:0]  data;

	modport src (output valid, op, addr, data);
	modport dst (input valid, op, addr, data);
endinterface

// Command result, execute to response
interface result_if;
	import uart_cmd_pkg::*;

	logic        valid;	// One-cycle pulse
	status_e     status;
	logic [7:0]  data;
	logic        busy;	// Response still on the line

	modport src (output valid, status, data, input busy);
	modport dst (input valid, status, data, output busy);
endinterface

/* design/baud_gen.sv */
`timescale 1ns/1ps

module baud_gen (
	input  logic clk,
	input  logic rstn,
	output logic b_tick
);
	import uart_cmd_pkg::*;

	logic [DIV_W-1:0] div_cnt;

	// Shared time base for rx and tx
	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			div_cnt <= '0;
			b_tick  <= 1'b0;
		end
		else if (div_cnt == DIV_W'(BAUD_DIV - 1))
		begin
			div_cnt <= '0;
			b_tick  <= 1'b1;	// One cycle on wrap
		end
		else
		begin
			div_cnt <= div_cnt + 1'b1;
			b_tick  <= 1'b0;
		end
	end

endmodule

/* design/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
	input  logic       clk,
	input  logic       rstn,
	input  logic       b_tick,
	input  logic       rx,
	input  logic       parity_en,
	output logic       rx_done,
	output logic       rx_err,
	output logic [7:0] dout
);
	import uart_cmd_pkg::*;

	ser_state_e        state_reg, state_next;
	logic [TICK_W-1:0] tick_reg, tick_next;	// Oversampling counter
	logic [2:0]        bit_reg, bit_next;	// Data bit index
	logic [7:0]        shift_reg, shift_next;
	logic              par_reg, par_next;	// Received parity bit
	logic              done_next, err_next;
	logic              sample;

	// Middle of a data, parity or stop bit
	assign sample = b_tick && (tick_reg == TICK_W'(OVERSAMPLE - 1));

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			state_reg <= ST_IDLE;
			tick_reg  <= '0;
			bit_reg   <= '0;
			shift_reg <= '0;
			par_reg   <= 1'b0;
			rx_done   <= 1'b0;
			rx_err    <= 1'b0;
		end
		else
		begin
			state_reg <= state_next;
			tick_reg  <= tick_next;
			bit_reg   <= bit_next;
			shift_reg <= shift_next;
			par_reg   <= par_next;
			rx_done   <= done_next;
			rx_err    <= err_next;
		end
	end

	// Held until the next good byte
	always_ff @(posedge clk)
	begin
		if (done_next)
			dout <= shift_reg;
	end

	always_comb
	begin
		state_next = state_reg;
		tick_next  = tick_reg;
		bit_next   = bit_reg;
		shift_next = shift_reg;
		par_next   = par_reg;
		done_next  = 1'b0;
		err_next   = 1'b0;

		case (state_reg)
			ST_IDLE:
				if (!rx)
				begin
					state_next = ST_START;
					tick_next  = '0;
				end
			ST_START:
				if (b_tick)
				begin
					if (tick_reg == TICK_W'(OVERSAMPLE / 2 - 1))
					begin
						tick_next = '0;
						bit_next  = '0;
						// Glitch if the line went back high
						state_next = rx ? ST_IDLE : ST_DATA;
					end
					else
						tick_next = tick_reg + 1'b1;
				end
			ST_DATA:
				if (sample)
				begin
					tick_next  = '0;
					shift_next = {rx, shift_reg[7:1]};	// LSB first
					if (bit_reg == 3'd7)
						state_next = parity_en ? ST_PARITY : ST_STOP;
					else
						bit_next = bit_reg + 1'b1;
				end
				else if (b_tick)
					tick_next = tick_reg + 1'b1;
			ST_PARITY:
				if (sample)
				begin
					tick_next  = '0;
					par_next   = rx;
					state_next = ST_STOP;
				end
				else if (b_tick)
					tick_next = tick_reg + 1'b1;
			ST_STOP:
				if (sample)
				begin
					state_next = ST_IDLE;
					// Stop must be high, parity even over data and parity bit
					if (rx && (!parity_en || !(^{par_reg, shift_reg})))
						done_next = 1'b1;
					else
						err_next = 1'b1;
				end
				else if (b_tick)
					tick_next = tick_reg + 1'b1;
			default:
				state_next = ST_IDLE;
		endcase
	end

	a_done_err_excl: assert property (@(posedge clk) disable iff (!rstn)
		!(rx_done && rx_err));

endmodule

/* design/cmd_decode.sv */
`timescale 1ns/1ps

module cmd_decode (
	input  logic       clk,
	input  logic       rstn,
	input  logic       rx_done,
	input  logic       rx_err,
	input  logic [7:0] rx_byte,
	cmd_if.src         cmd
);
	import uart_cmd_pkg::*;

	logic [1:0] pos;	// Byte position in the frame
	logic [7:0] op_byte;
	logic [7:0] addr_byte;

	function automatic cmd_op_e decode_op(input logic [7:0] code);
		case (code)
			8'h01:   return OP_WRITE;
			8'h02:   return OP_READ;
			8'h03:   return OP_ADD;
			8'h04:   return OP_XOR;
			default: return OP_BAD;
		endcase
	endfunction

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			pos       <= '0;
			cmd.valid <= 1'b0;
		end
		else
		begin
			cmd.valid <= 1'b0;
			if (rx_err)
				pos <= '0;	// Resync on a bad byte
			else if (rx_done)
			begin
				if (pos == 2'd2)
				begin
					pos       <= '0;
					cmd.valid <= 1'b1;
				end
				else
					pos <= pos + 1'b1;
			end
		end
	end

	// Frame bytes
	always_ff @(posedge clk)
	begin
		if (rx_done)
		begin
			case (pos)
				2'd0: op_byte   <= rx_byte;
				2'd1: addr_byte <= rx_byte;
				2'd2:
				begin
					cmd.op   <= decode_op(op_byte);
					cmd.addr <= addr_byte;
					cmd.data <= rx_byte;
				end
				default: ;
			endcase
		end
	end

endmodule

/* design/cmd_execute.sv */
`timescale 1ns/1ps

module cmd_execute (
	input  logic clk,
	input  logic rstn,
	cmd_if.dst   cmd,
	result_if.src res
);
	import uart_cmd_pkg::*;

	logic [7:0]        regs [REG_COUNT];
	logic [ADDR_W-1:0] idx;
	logic [7:0]        cur_val;
	logic [7:0]        new_val;
	logic [7:0]        resp_data;
	status_e           resp_stat;
	logic              wr_en;

	always_comb
	begin
		idx       = cmd.addr[ADDR_W-1:0];
		cur_val   = regs[idx];
		new_val   = cur_val;
		resp_stat = STAT_OK;

		case (cmd.op)
			OP_WRITE: new_val = cmd.data;
			OP_READ:  new_val = cur_val;
			OP_ADD:   new_val = cur_val + cmd.data;	// Wraps mod 256
			OP_XOR:   new_val = cur_val ^ cmd.data;
			default:  resp_stat = STAT_BAD_OP;
		endcase

		// Opcode error wins over address error
		if (resp_stat == STAT_OK && cmd.addr >= 8'(REG_COUNT))
			resp_stat = STAT_BAD_ADDR;

		wr_en     = cmd.valid && (resp_stat == STAT_OK);
		resp_data = (resp_stat == STAT_OK) ? new_val : 8'h00;
	end

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= 8'h00;
			res.valid <= 1'b0;
		end
		else
		begin
			if (wr_en)
				regs[idx] <= new_val;
			res.valid <= cmd.valid;	// One cycle after the command
		end
	end

	always_ff @(posedge clk)
	begin
		if (cmd.valid)
		begin
			res.status <= resp_stat;
			res.data   <= resp_data;
		end
	end

	// Host must wait for the previous response
	a_no_overrun: assert property (@(posedge clk) disable iff (!rstn)
		res.valid |-> !res.busy);

endmodule

/* design/resp_tx.sv */
`timescale 1ns/1ps

module resp_tx (
	input  logic  clk,
	input  logic  rstn,
	input  logic  b_tick,
	input  logic  parity_en,
	result_if.dst res,
	output logic  tx
);
	import uart_cmd_pkg::*;

	ser_state_e        state;
	logic [TICK_W-1:0] tick_cnt;
	logic [2:0]        bit_cnt;
	logic              second;	// Sending the data byte
	logic [7:0]        cur_byte;
	logic [7:0]        next_byte;
	logic              bit_end;
	logic              frame_load;
	logic              frame_next;

	assign bit_end    = b_tick && (tick_cnt == TICK_W'(OVERSAMPLE - 1));
	assign frame_load = (state == ST_IDLE) && res.valid;
	assign frame_next = (state == ST_STOP) && bit_end && !second;

	// Status first, then data
	always_ff @(posedge clk)
	begin
		if (frame_load)
		begin
			cur_byte  <= res.status;
			next_byte <= res.data;
		end
		else if (frame_next)
			cur_byte <= next_byte;
	end

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			state     <= ST_IDLE;
			tick_cnt  <= '0;
			bit_cnt   <= '0;
			second    <= 1'b0;
			tx        <= 1'b1;	// Line idles high
			res.busy  <= 1'b0;
		end
		else
		begin
			if (b_tick && state != ST_IDLE)
				tick_cnt <= bit_end ? '0 : tick_cnt + 1'b1;

			case (state)
				ST_IDLE:
					if (res.valid)
					begin
						state    <= ST_START;
						tick_cnt <= '0;
						second   <= 1'b0;
						tx       <= 1'b0;
						res.busy <= 1'b1;
					end
				ST_START:
					if (bit_end)
					begin
						state   <= ST_DATA;
						bit_cnt <= '0;
						tx      <= cur_byte[0];
					end
				ST_DATA:
					if (bit_end)
					begin
						if (bit_cnt == 3'd7)
						begin
							if (parity_en)
							begin
								state <= ST_PARITY;
								tx    <= ^cur_byte;	// Even parity
							end
							else
							begin
								state <= ST_STOP;
								tx    <= 1'b1;
							end
						end
						else
						begin
							bit_cnt <= bit_cnt + 1'b1;
							tx      <= cur_byte[bit_cnt + 3'd1];
						end
					end
				ST_PARITY:
					if (bit_end)
					begin
						state <= ST_STOP;
						tx    <= 1'b1;
					end
				ST_STOP:
					if (bit_end)
					begin
						if (!second)
						begin
							second <= 1'b1;
							state  <= ST_START;
							tx     <= 1'b0;
						end
						else
						begin
							state    <= ST_IDLE;
							res.busy <= 1'b0;
						end
					end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	a_idle_high: assert property (@(posedge clk) disable iff (!rstn)
		(state == ST_IDLE) |-> tx);

endmodule

/* design/uart_cmd_top.sv */
`timescale 1ns/1ps

module uart_cmd_top (
	input  logic clk,
	input  logic rstn,
	input  logic rx,
	input  logic parity_en,
	output logic tx,
	output logic rx_err
);

	logic       b_tick;
	logic       rx_done;
	logic [7:0] rx_byte;

	cmd_if    cmd ();
	result_if res ();

	baud_gen u_baud (
		.clk    (clk),
		.rstn   (rstn),
		.b_tick (b_tick)
	);

	uart_rx u_rx (
		.clk       (clk),
		.rstn      (rstn),
		.b_tick    (b_tick),
		.rx        (rx),
		.parity_en (parity_en),
		.rx_done   (rx_done),
		.rx_err    (rx_err),
		.dout      (rx_byte)
	);

	cmd_decode u_decode (
		.clk     (clk),
		.rstn    (rstn),
		.rx_done (rx_done),
		.rx_err  (rx_err),
		.rx_byte (rx_byte),
		.cmd     (cmd.src)
	);

	cmd_execute u_exec (
		.clk  (clk),
		.rstn (rstn),
		.cmd  (cmd.dst),
		.res  (res.src)
	);

	resp_tx u_tx (
		.clk       (clk),
		.rstn      (rstn),
		.b_tick    (b_tick),
		.parity_en (parity_en),
		.res       (res.dst),
		.tx        (tx)
	);

endmodule

/* verif/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker (
	input  logic clk,
	input  logic rstn,
	input  logic rx,
	input  logic parity_en,
	input  logic tx,
	input  logic rx_err,
	output int   err_count,
	output int   check_count,
	output int   resp_count,
	output int   rx_err_miss
);
	import uart_cmd_pkg::*;

	localparam int BIT_CYC = BAUD_DIV * OVERSAMPLE;

	string       test_name = "idle_tx";
	logic [7:0]  shadow [REG_COUNT] = '{default: 8'h00};	// Reference register bank
	logic [15:0] exp_q [$];	// {status, data} per outstanding frame

	// Reference model of one command frame
	function automatic logic [15:0] ref_exec(input logic [7:0] op, input logic [7:0] addr,
		input logic [7:0] data);
		logic [7:0] val;
		if (!(op inside {8'h01, 8'h02, 8'h03, 8'h04}))
			return {STAT_BAD_OP, 8'h00};
		if (addr >= 8'(REG_COUNT))
			return {STAT_BAD_ADDR, 8'h00};
		val = shadow[addr[2:0]];
		case (op)
			8'h01: val = data;
			8'h03: val = val + data;	// Modulo 256
			8'h04: val = val ^ data;
			default: ;	// Read leaves it alone
		endcase
		shadow[addr[2:0]] = val;
		return {STAT_OK, val};
	endfunction

	task automatic check_val(input string what, input logic [7:0] want, input logic [7:0] act);
		check_count++;
		if (act !== want)
		begin
			err_count++;
			$display("[FAIL] %s %s: expected %02h, actual %02h", test_name, what, want, act);
		end
	endtask

	// Called on the first edge that sees the start bit low
	task automatic get_byte(input logic from_tx, input int ofs, output logic [7:0] b,
		output logic ok);
		logic p;
		logic pe;
		pe = parity_en;
		p  = 1'b0;
		b  = 8'h00;
		repeat (ofs) @(posedge clk);
		repeat (8)
		begin
			repeat (BIT_CYC) @(posedge clk);
			b = {(from_tx ? tx : rx), b[7:1]};	// LSB first
		end
		if (pe)
		begin
			repeat (BIT_CYC) @(posedge clk);
			p = from_tx ? tx : rx;
		end
		repeat (BIT_CYC) @(posedge clk);
		ok = (from_tx ? tx : rx) && !(pe && (^{b, p}));
	endtask

	task automatic wait_tx_start(output logic found);
		int t;
		t     = 0;
		found = 1'b0;
		while (!found && t < 2 * BIT_CYC)
		begin
			@(posedge clk);
			found = !tx;
			t++;
		end
	endtask

	// Host side, sampled early in each bit so the expectation is queued before tx starts
	initial
	begin : rx_monitor
		logic [7:0]  b;
		logic [23:0] frame;
		logic        ok;
		logic        seen;
		int          pos;
		int          t;
		pos         = 0;
		frame       = '0;
		rx_err_miss = 0;
		forever
		begin
			@(posedge clk);
			if (rstn && !rx)
			begin
				get_byte(1'b0, 7, b, ok);
				if (!ok)
				begin
					pos  = 0;	// Frame dropped
					seen = 1'b0;
					t    = 0;
					while (!seen && t < BIT_CYC / 2 + 4)
					begin
						@(posedge clk);
						seen = rx_err;
						t++;
					end
					if (!seen)
					begin
						rx_err_miss++;
						$display("ERROR: %s: no rx_err pulse after a bad byte", test_name);
					end
				end
				else
				begin
					frame = {frame[15:0], b};
					pos++;
					if (pos == 3)
					begin
						exp_q.push_back(ref_exec(frame[23:16], frame[15:8], frame[7:0]));
						pos = 0;
					end
				end
			end
		end
	end

	initial
	begin : tx_compare
		logic [7:0]  st;
		logic [7:0]  dt;
		logic        ok_s;
		logic        ok_d;
		logic        got;
		logic [15:0] want;
		int          t;
		err_count   = 0;
		check_count = 0;
		resp_count  = 0;
		t           = 0;
		while (!rstn && t < 100)
		begin
			@(posedge clk);
			t++;
		end
		@(posedge clk);
		check_val("tx", 8'h01, {7'd0, tx});	// Idle line after reset
		t = 0;
		forever
		begin
			@(posedge clk);
			if (rstn && !tx)
			begin
				t    = 0;
				ok_d = 1'b0;
				dt   = 8'h00;
				get_byte(1'b1, 15, st, ok_s);
				wait_tx_start(got);
				if (got)
					get_byte(1'b1, 15, dt, ok_d);
				if (exp_q.size() == 0)
				begin
					err_count++;
					$display("ERROR: %s: response on tx with no command outstanding", test_name);
				end
				else
				begin
					want = exp_q.pop_front();
					if (!got)
					begin
						err_count++;
						$display("ERROR: %s: second response byte never started", test_name);
					end
					else
					begin
						check_val("status", want[15:8], st);
						check_val("data", want[7:0], dt);
						if (!ok_s || !ok_d)
						begin
							err_count++;
							$display("ERROR: %s: response has bad parity or stop bit", test_name);
						end
					end
				end
				resp_count++;
			end
			else if (exp_q.size() > 0)
			begin
				t++;
				if (t > 4 * BIT_CYC)
				begin
					err_count++;
					$display("ERROR: %s: no start bit on tx for a command", test_name);
					void'(exp_q.pop_front());
					resp_count++;
					t = 0;
				end
			end
		end
	end

endmodule

/* verif/tb_top.sv */
`timescale 1ns/1ps

module tb_top;
	import uart_cmd_pkg::*;

	localparam int BIT_CYC  = BAUD_DIV * OVERSAMPLE;
	localparam int RESP_MAX = 40 * BIT_CYC;	// Frame plus response, with margin

	logic clk;
	logic rstn;
	logic rx;
	logic parity_en;
	logic tx;
	logic rx_err;
	int   err_count;
	int   check_count;
	int   resp_count;
	int   rx_err_miss;
	int   n_expect;
	int   timeouts;

	uart_cmd_top UUT (
		.clk       (clk),
		.rstn      (rstn),
		.rx        (rx),
		.parity_en (parity_en),
		.tx        (tx),
		.rx_err    (rx_err)
	);

	tb_checker chk (
		.clk         (clk),
		.rstn        (rstn),
		.rx          (rx),
		.parity_en   (parity_en),
		.tx          (tx),
		.rx_err      (rx_err),
		.err_count   (err_count),
		.check_count (check_count),
		.resp_count  (resp_count),
		.rx_err_miss (rx_err_miss)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// One bit cell, entered on a rising edge
	task automatic drive_bit(input logic v);
		rx <= v;
		repeat (BIT_CYC) @(posedge clk);
	endtask

	task automatic send_byte(input logic [7:0] b, input logic flip_par);
		logic [7:0] sh;
		sh = b;
		drive_bit(1'b0);
		repeat (8)
		begin
			drive_bit(sh[0]);
			sh = sh >> 1;
		end
		if (parity_en)
			drive_bit(^b ^ flip_par);	// Even unless flipped
		drive_bit(1'b1);
	endtask

	task automatic wait_resp();
		int t;
		t = 0;
		while (resp_count < n_expect && t < RESP_MAX)
		begin
			@(posedge clk);
			t++;
		end
		if (resp_count < n_expect)
		begin
			$display("ERROR: %s: timed out waiting for response %0d", chk.test_name, n_expect);
			timeouts++;
			n_expect = resp_count;
		end
	endtask

	task automatic send_frame(input logic [7:0] op, input logic [7:0] addr,
		input logic [7:0] data);
		send_byte(op, 1'b0);
		send_byte(addr, 1'b0);
		send_byte(data, 1'b0);
		n_expect++;
		wait_resp();
	endtask

	task automatic run_random(input int n);
		logic [7:0] op;
		for (int i = 0; i < n; i++)
		begin
			case ($urandom_range(0, 9))
				0, 1:    op = OP_WRITE;
				2, 3:    op = OP_READ;
				4, 5:    op = OP_ADD;
				6, 7:    op = OP_XOR;
				default: op = 8'($urandom);	// Mostly undefined codes
			endcase
			send_frame(op, 8'($urandom_range(0, REG_COUNT + 1)), 8'($urandom));
		end
	endtask

	initial
	begin
		void'($urandom(32'haef5_e07c));
		rx        = 1'b1;
		parity_en = 1'b0;
		rstn      = 1'b0;
		n_expect  = 0;
		timeouts  = 0;
		repeat (5) @(posedge clk);
		rstn <= 1'b1;
		repeat (4) @(posedge clk);

		chk.test_name = "reset_read";
		for (int i = 0; i < REG_COUNT; i++)
			send_frame(OP_READ, 8'(i), 8'h00);

		chk.test_name = "write_readback";
		for (int i = 0; i < REG_COUNT; i++)
			send_frame(OP_WRITE, 8'(i), 8'($urandom));
		for (int i = 0; i < REG_COUNT; i++)
			send_frame(OP_READ, 8'(i), 8'($urandom));

		chk.test_name = "add_xor";
		send_frame(OP_WRITE, 8'h05, 8'hf0);
		send_frame(OP_ADD, 8'h05, 8'h25);	// Wraps past 255
		for (int i = 0; i < 12; i++)
			send_frame(($urandom_range(0, 1) == 1) ? OP_ADD : OP_XOR,
				8'($urandom_range(0, REG_COUNT - 1)), 8'($urandom));

		chk.test_name = "bad_cmd";
		send_frame(OP_WRITE, 8'h03, 8'h5a);
		send_frame(OP_WRITE, 8'h0b, 8'h11);	// Aliases reg 3 if the check were missing
		send_frame(OP_ADD, 8'(REG_COUNT), 8'h11);
		send_frame(8'h07, 8'h03, 8'h22);
		send_frame(8'h00, 8'hff, 8'h22);
		send_frame(OP_READ, 8'h03, 8'h00);
		send_frame(OP_READ, 8'h00, 8'h00);

		chk.test_name = "parity_drop";
		parity_en <= 1'b1;
		@(posedge clk);
		send_byte(OP_WRITE, 1'b0);
		send_byte(8'h02, 1'b1);
		repeat (30 * BIT_CYC) @(posedge clk);	// Quiet line, no response allowed
		send_frame(OP_WRITE, 8'h02, 8'h3c);
		send_frame(OP_READ, 8'h02, 8'h00);

		chk.test_name = "random_no_parity";
		parity_en <= 1'b0;
		@(posedge clk);
		run_random(16);
		chk.test_name = "random_parity";
		parity_en <= 1'b1;
		@(posedge clk);
		run_random(16);

		repeat (4 * BIT_CYC) @(posedge clk);
		$display("Checks: %0d, errors: %0d, missed rx_err: %0d, timeouts: %0d",
			check_count, err_count, rx_err_miss, timeouts);
		if (err_count == 0 && rx_err_miss == 0 && timeouts == 0 && check_count > 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* filelist.f */
design/uart_cmd_pkg.sv
design/cmd_if.sv
design/baud_gen.sv
design/uart_rx.sv
design/cmd_decode.sv
design/cmd_execute.sv
design/resp_tx.sv
design/uart_cmd_top.sv
verif/tb_checker.sv
verif/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_top -f filelist.f -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -qx "All checks passed" sim.log; then
	echo "Simulation PASSED"
	exit 0
fi

echo "Simulation FAILED"
exit 1
